// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= core_commit_tb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== source/arch_regfile.sv ====
// architectural registers; one write, one async read, r0 reads zero and ignores writes
`include "core_params.svh"
`default_nettype none

module arch_regfile (
    input  wire logic                   clock,
    input  wire logic                   rst,
    input  wire logic                   we,
    input  wire logic [`CORE_REG_W-1:0] waddr,
    input  wire logic [`CORE_XLEN-1:0]  wdata,
    input  wire logic [`CORE_REG_W-1:0] raddr,
    output logic [`CORE_XLEN-1:0]       rdata
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    //////////////////////////////////////////////////
    // write port
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NREGS; i++)
                regs[i] <= '0;   // whole file starts at zero
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // read port, no bypass of same-cycle write
    always_comb begin
        if (raddr == '0)
            rdata = '0;          // hard zero
        else
            rdata = regs[raddr];
    end

endmodule

`default_nettype wire

// ==== source/commit_pkg.sv ====
// commit control types; store machine handles one outstanding write at a time
`default_nettype none

package commit_pkg;

    // store commit sequencing
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,  // waiting for a retired store
        ST_REQ     = 2'd1,  // mem_req high, waiting for ack
        ST_RELEASE = 2'd2   // mem_req low, waiting for ack to drop
    } store_state_e;

endpackage

`default_nettype wire

// ==== source/core_commit_top.sv ====
// commit back end of the core; no fetch or execute, loads never reach memory here
`include "core_params.svh"
`default_nettype none

module core_commit_top (
    input  wire logic                   clock,
    input  wire logic                   rst,

    // dispatch
    input  wire logic                   alloc_valid,
    input  wire rob_pkg::rob_op_e       alloc_op,
    input  wire logic [`CORE_REG_W-1:0] alloc_dest,
    output logic                        alloc_ready,
    output rob_pkg::rob_tag_t           alloc_tag,

    // completion
    input  wire logic                   complete_valid,
    input  wire rob_pkg::rob_tag_t      complete_tag,
    input  wire logic [`CORE_XLEN-1:0]  complete_value,
    input  wire logic [`CORE_XLEN-1:0]  complete_addr,
    input  wire logic                   complete_mispredict,

    // retire trace
    output logic                        retire_valid,
    output logic [`CORE_REG_W-1:0]      retire_dest,
    output logic [`CORE_XLEN-1:0]       retire_value,

    // debug read of arch state
    input  wire logic [`CORE_REG_W-1:0] read_index,
    output logic [`CORE_XLEN-1:0]       read_value,

    // memory write port, four-phase
    output logic                        mem_req,
    output logic [`CORE_XLEN-1:0]       mem_addr,
    output logic [`CORE_XLEN-1:0]       mem_data,
    input  wire logic                   mem_ack
);

    //////////////////////////////////////////////////
    // internal links
    logic                   head_valid;
    rob_pkg::rob_entry_t    head_entry;
    logic                   head_accept;
    logic                   flush;
    logic                   rf_we;
    logic [`CORE_REG_W-1:0] rf_waddr;
    logic [`CORE_XLEN-1:0]  rf_wdata;

    store_if store_link ();   // retire to store machine

    reorder_buffer u_rob (
        .clock, .rst,
        .alloc_valid, .alloc_op, .alloc_dest, .alloc_ready, .alloc_tag,
        .complete_valid, .complete_tag, .complete_value, .complete_addr,
        .complete_mispredict,
        .head_valid, .head_entry, .head_accept, .flush
    );

    retire_stage u_retire (
        .clock, .rst,
        .head_valid, .head_entry, .head_accept, .flush,
        .store (store_link.issuer),
        .retire_valid, .retire_dest, .retire_value,
        .rf_we, .rf_waddr, .rf_wdata
    );

    store_commit_fsm u_store (
        .clock, .rst,
        .store (store_link.committer),
        .mem_req, .mem_addr, .mem_data, .mem_ack
    );

    arch_regfile u_regfile (
        .clock, .rst,
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata),
        .raddr (read_index),
        .rdata (read_value)
    );

endmodule

`default_nettype wire

// ==== source/core_params.svh ====
// core sizing macros; ROB depth must be a power of two and CORE_TAG_W must equal its log2
`default_nettype none

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

//////////////////////////////////////////////////
// datapath
`define CORE_XLEN       64  // data and address width
`define CORE_NREGS      32  // architectural registers
`define CORE_REG_W      5   // log2 of CORE_NREGS

//////////////////////////////////////////////////
// reorder buffer
`define CORE_ROB_DEPTH  8   // entries, power of two
`define CORE_TAG_W      3   // log2 of CORE_ROB_DEPTH

`endif

`default_nettype wire

// ==== source/reorder_buffer.sv ====
// in-order ROB; unallocated completion tags are dropped, flush discards everything still held
`include "core_params.svh"
`default_nettype none

module reorder_buffer (
    input  wire logic                   clock,
    input  wire logic                   rst,

    // dispatch
    input  wire logic                   alloc_valid,
    input  wire rob_pkg::rob_op_e       alloc_op,
    input  wire logic [`CORE_REG_W-1:0] alloc_dest,
    output logic                        alloc_ready,
    output rob_pkg::rob_tag_t           alloc_tag,

    // completion, any order
    input  wire logic                   complete_valid,
    input  wire rob_pkg::rob_tag_t      complete_tag,
    input  wire logic [`CORE_XLEN-1:0]  complete_value,
    input  wire logic [`CORE_XLEN-1:0]  complete_addr,
    input  wire logic                   complete_mispredict,

    // oldest entry to retire
    output logic                        head_valid,
    output rob_pkg::rob_entry_t         head_entry,
    input  wire logic                   head_accept,
    input  wire logic                   flush
);

    localparam logic [`CORE_TAG_W:0] DEPTH = (`CORE_TAG_W + 1)'(`CORE_ROB_DEPTH);

    rob_pkg::rob_entry_t     entries [`CORE_ROB_DEPTH];  // slot storage
    rob_pkg::rob_tag_t       head;                       // oldest
    rob_pkg::rob_tag_t       tail;                       // next free
    logic [`CORE_TAG_W:0]    count;                      // occupancy, 0..DEPTH

    logic                    alloc_fire;
    logic                    cpl_hit;
    logic [`CORE_TAG_W-1:0]  cpl_offset;  // distance of completing tag from head

    //////////////////////////////////////////////////
    // handshakes

    assign alloc_ready = (count != DEPTH) && !flush;   // full or flushing blocks dispatch
    assign alloc_fire  = alloc_valid && alloc_ready;
    assign alloc_tag   = tail;                          // tag shown before the edge

    // tag must sit inside the live window head..head+count-1
    assign cpl_offset  = complete_tag - head;           // wraps, depth is a power of two
    assign cpl_hit     = complete_valid && ({1'b0, cpl_offset} < count);

    assign head_entry  = entries[head];
    assign head_valid  = (count != '0) && head_entry.done;

    //////////////////////////////////////////////////
    // pointers and occupancy

    always_ff @(posedge clock) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            tail  <= head;   // both pointers meet at the head, new tags continue from it
            count <= '0;
        end else begin
            if (alloc_fire)
                tail <= tail + 1'b1;
            if (head_accept)
                head <= head + 1'b1;   // retire only accepts a valid head

            case ({alloc_fire, head_accept})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // none, or one in one out
            endcase
        end
    end

    //////////////////////////////////////////////////
    // slot contents

    // done bit only trusted inside the live window, so no clear here
    always_ff @(posedge clock) begin
        if (alloc_fire) begin
            entries[tail] <= '{
                op:         alloc_op,
                dest:       alloc_dest,
                value:      '0,
                mem_addr:   '0,
                mispredict: 1'b0,
                done:       1'b0
            };
        end
        // full buffer means no alloc, so this never hits the slot being filled
        if (cpl_hit) begin
            entries[complete_tag].value      <= complete_value;
            entries[complete_tag].mem_addr   <= complete_addr;
            entries[complete_tag].mispredict <= complete_mispredict;
            entries[complete_tag].done       <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/retire_stage.sv ====
// registered retire; holds off while a store is in flight, flush lasts exactly one cycle
`include "core_params.svh"
`default_nettype none

module retire_stage (
    input  wire logic                   clock,
    input  wire logic                   rst,
    input  wire logic                   head_valid,
    input  wire rob_pkg::rob_entry_t    head_entry,
    output logic                        head_accept,
    output logic                        flush,
    store_if.issuer                     store,
    output logic                        retire_valid,   // trace
    output logic [`CORE_REG_W-1:0]      retire_dest,
    output logic [`CORE_XLEN-1:0]       retire_value,
    output logic                        rf_we,          // to regfile, next edge
    output logic [`CORE_REG_W-1:0]      rf_waddr,
    output logic [`CORE_XLEN-1:0]       rf_wdata
);

    logic writes_reg;

    // pending pulse counts as outstanding too, busy only rises an edge later
    assign head_accept = head_valid && !store.store_busy && !store.store_valid && !flush;

    assign writes_reg = (head_entry.op == rob_pkg::OP_ALU || head_entry.op == rob_pkg::OP_LOAD)
                        && (head_entry.dest != '0);   // r0 never written

    //////////////////////////////////////////////////
    // control flags
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            retire_valid      <= 1'b0;
            rf_we             <= 1'b0;
            store.store_valid <= 1'b0;
            flush             <= 1'b0;   // self clearing
        end else begin
            retire_valid      <= head_accept;
            rf_we             <= head_accept && writes_reg;
            store.store_valid <= head_accept && (head_entry.op == rob_pkg::OP_STORE);
            flush             <= head_accept && (head_entry.op == rob_pkg::OP_BRANCH)
                                 && head_entry.mispredict;
        end
    end

    // payload, captured on accept only
    always_ff @(posedge clock) begin
        if (head_accept) begin
            retire_dest      <= head_entry.dest;
            retire_value     <= head_entry.value;
            store.store_addr <= head_entry.mem_addr;
            store.store_data <= head_entry.value;   // store data rides in value
        end
    end

    assign rf_waddr = retire_dest;
    assign rf_wdata = retire_value;

endmodule

`default_nettype wire

// ==== source/rob_pkg.sv ====
// in-flight instruction types; entry width follows CORE_XLEN, no exception or pc fields
`include "core_params.svh"
`default_nettype none

package rob_pkg;

    // opcode classes seen by commit
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,   // register result
        OP_LOAD   = 2'd1,   // register result, memory already read
        OP_STORE  = 2'd2,   // memory write at retire
        OP_BRANCH = 2'd3    // may flush
    } rob_op_e;

    // slot index into the reorder buffer
    typedef logic [`CORE_TAG_W-1:0] rob_tag_t;

    // one reorder buffer slot, roughly 136 bits
    typedef struct packed {
        rob_op_e                op;
        logic [`CORE_REG_W-1:0] dest;        // arch destination
        logic [`CORE_XLEN-1:0]  value;       // result or store data
        logic [`CORE_XLEN-1:0]  mem_addr;    // store address
        logic                   mispredict;  // branch resolved wrong
        logic                   done;        // result arrived
    } rob_entry_t;

endpackage

`default_nettype wire

// ==== source/store_commit_fsm.sv ====
// one four-phase write per store; a store_valid seen outside ST_IDLE is ignored
`include "core_params.svh"
`default_nettype none

module store_commit_fsm (
    input  wire logic                  clock,
    input  wire logic                  rst,
    store_if.committer                 store,
    output logic                       mem_req,
    output logic [`CORE_XLEN-1:0]      mem_addr,   // stable while mem_req high
    output logic [`CORE_XLEN-1:0]      mem_data,
    input  wire logic                  mem_ack
);

    commit_pkg::store_state_e state;
    commit_pkg::store_state_e state_next;

    //////////////////////////////////////////////////
    // next state
    always_comb begin
        state_next = state;
        case (state)
            commit_pkg::ST_IDLE: begin
                if (store.store_valid)
                    state_next = commit_pkg::ST_REQ;       // request next edge
            end
            commit_pkg::ST_REQ: begin
                if (mem_ack)
                    state_next = commit_pkg::ST_RELEASE;   // phase 2 seen, drop req
            end
            commit_pkg::ST_RELEASE: begin
                if (!mem_ack)
                    state_next = commit_pkg::ST_IDLE;      // phase 4, handshake closed
            end
            default: begin
                state_next = commit_pkg::ST_IDLE;          // unused encoding
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst)
            state <= commit_pkg::ST_IDLE;
        else
            state <= state_next;
    end

    //////////////////////////////////////////////////
    // address and data latch

    // only loaded from idle, so held through req and release
    always_ff @(posedge clock) begin
        if (state == commit_pkg::ST_IDLE && store.store_valid) begin
            mem_addr <= store.store_addr;
            mem_data <= store.store_data;
        end
    end

    // outputs straight from state
    assign mem_req          = (state == commit_pkg::ST_REQ);
    assign store.store_busy = (state != commit_pkg::ST_IDLE);  // covers release phase too

endmodule

`default_nettype wire

// ==== source/store_if.sv ====
// retire to store-commit link; issuer may pulse store_valid only while store_busy is low
`include "core_params.svh"
`default_nettype none

interface store_if;

    logic                  store_valid;  // one cycle pulse per store
    logic [`CORE_XLEN-1:0] store_addr;   // held with the pulse
    logic [`CORE_XLEN-1:0] store_data;
    logic                  store_busy;   // high until handshake fully done

    // retire side
    modport issuer (
        output store_valid, store_addr, store_data,
        input  store_busy
    );

    // memory side
    modport committer (
        input  store_valid, store_addr, store_data,
        output store_busy
    );

endinterface

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/rob_pkg.sv
source/commit_pkg.sv
source/store_if.sv
source/reorder_buffer.sv
source/retire_stage.sv
source/store_commit_fsm.sv
source/arch_regfile.sv
source/core_commit_top.sv
verification/core_commit_tb.sv

// ==== verification/core_commit_tb.sv ====
// bench for core_commit_top; random ack delay of 0..5 cycles and the first error ends the run
`include "core_params.svh"
`default_nettype none

module core_commit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic clock, rst, alloc_valid, alloc_ready, complete_valid, complete_mispredict;
    rob_pkg::rob_op_e       alloc_op;
    logic [`CORE_REG_W-1:0] alloc_dest, retire_dest, read_index;
    rob_pkg::rob_tag_t      alloc_tag, complete_tag;
    logic [`CORE_XLEN-1:0]  complete_value, complete_addr, retire_value, read_value;
    logic [`CORE_XLEN-1:0]  mem_addr, mem_data;
    logic                   retire_valid, mem_req, mem_ack;

    core_commit_top DUT (.*);

    //////////////////////////////////////////////////
    // reference model
    logic [`CORE_REG_W-1:0] exp_dest [$];
    logic [`CORE_XLEN-1:0]  exp_val [$], st_addr [$], st_data [$];
    rob_pkg::rob_op_e       exp_op [$];
    logic [`CORE_XLEN-1:0]  shadow [`CORE_NREGS];
    logic [`CORE_XLEN-1:0]  pend_val [`CORE_ROB_DEPTH], pend_addr [`CORE_ROB_DEPTH];
    logic                   pend_mis [`CORE_ROB_DEPTH];
    logic                   store_pending, prev_req, prev_ack, hold_ack;
    string                  test_name;
    int                     cycles;

    task automatic abort_run(input string what);
        $display("%s (test %s)", what, test_name);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run("value mismatch");
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;   // 10 ns
    end

    always @(posedge clock) begin   // watchdog
        cycles <= cycles + 1;
        if (cycles >= 4000)
            abort_run("timeout, run did not finish within 4000 cycles");
    end

    //////////////////////////////////////////////////
    // four-phase protocol
    a_req_held: assert property (@(posedge clock) disable iff (rst)
        $fell(mem_req) |-> $past(mem_ack))
        else abort_run("mem_req dropped before mem_ack rose");
    a_no_rerise: assert property (@(posedge clock) disable iff (rst)
        $rose(mem_req) |-> !mem_ack)
        else abort_run("mem_req rose again while mem_ack still high");
    a_stable: assert property (@(posedge clock) disable iff (rst)
        mem_req && $past(mem_req) |-> $stable(mem_addr) && $stable(mem_data))
        else abort_run("mem_addr or mem_data changed while mem_req high");

    // trace and store order against the model
    always @(posedge clock) begin
        if (rst) begin
            store_pending = 1'b0;   // model restarts with the DUT
            for (int r = 0; r < `CORE_NREGS; r++)
                shadow[r] = '0;
        end else begin
            if (retire_valid) begin
                if (store_pending) abort_run("retire pulse inside an open store handshake");
                if (exp_dest.size() == 0) abort_run("unexpected retire, flushed work escaped");
                check_val("retire_dest", exp_dest[0], retire_dest);
                check_val("retire_value", exp_val[0], retire_value);
                if (exp_op[0] == rob_pkg::OP_STORE)
                    store_pending = 1'b1;
                else if (exp_op[0] inside {rob_pkg::OP_ALU, rob_pkg::OP_LOAD}
                         && exp_dest[0] != 0)
                    shadow[exp_dest[0]] = exp_val[0];   // in-order arch update
                void'(exp_dest.pop_front());
                void'(exp_val.pop_front());
                void'(exp_op.pop_front());
            end
            if (mem_req && !prev_req) begin   // new write checked against the next store
                if (st_addr.size() == 0) abort_run("memory write with no store retired");
                check_val("mem_addr", st_addr.pop_front(), mem_addr);
                check_val("mem_data", st_data.pop_front(), mem_data);
            end
            if (prev_ack && !mem_ack) store_pending = 1'b0;   // phase 4 done
        end
        prev_req = mem_req;
        prev_ack = mem_ack;
    end

    // memory responder with random ack delay
    initial begin
        mem_ack = 1'b0;
        forever begin
            @(posedge clock);
            if (mem_req && !hold_ack) begin
                repeat ($urandom_range(0, 5)) @(posedge clock);
                mem_ack <= 1'b1;
                do @(posedge clock); while (mem_req);
                mem_ack <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    task automatic dispatch(input rob_pkg::rob_op_e op, input logic [4:0] dest,
                            input logic [63:0] val, input logic [63:0] addr, input logic mis,
                            input bit retires, output rob_pkg::rob_tag_t tag);
        @(posedge clock);
        alloc_valid <= 1'b1;
        alloc_op    <= op;
        alloc_dest  <= dest;
        do @(posedge clock); while (!alloc_ready);
        tag = alloc_tag;   // tail before the accept edge
        alloc_valid <= 1'b0;
        pend_val[tag]  = val;
        pend_addr[tag] = addr;
        pend_mis[tag]  = mis;
        if (retires) begin
            exp_dest.push_back(dest);
            exp_val.push_back(val);
            exp_op.push_back(op);
            if (op == rob_pkg::OP_STORE) begin
                st_addr.push_back(addr);
                st_data.push_back(val);
            end
        end
    endtask

    task automatic complete_random(input rob_pkg::rob_tag_t tags [$]);
        int i;
        while (tags.size() > 0) begin
            i = $urandom_range(0, tags.size() - 1);
            @(posedge clock);
            complete_valid      <= 1'b1;
            complete_tag        <= tags[i];
            complete_value      <= pend_val[tags[i]];
            complete_addr       <= pend_addr[tags[i]];
            complete_mispredict <= pend_mis[tags[i]];
            tags.delete(i);
        end
        @(posedge clock);
        complete_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_dest.size() != 0 || mem_req || mem_ack || store_pending || alloc_valid)
            @(posedge clock);
        repeat (3) @(posedge clock);   // regfile write lands two edges later
    endtask

    task automatic compare_regfile();
        for (int r = 0; r < `CORE_NREGS; r++) begin
            @(posedge clock);
            read_index <= r[`CORE_REG_W-1:0];
            @(posedge clock);
            check_val($sformatf("read_value r%0d", r), shadow[r], read_value);
        end
    endtask

    initial begin
        rob_pkg::rob_tag_t tags [$];
        rob_pkg::rob_tag_t t, br_tag;
        void'($urandom(32'hde64fe19));
        {alloc_valid, complete_valid, complete_mispredict, hold_ack} = '0;
        alloc_op = rob_pkg::OP_ALU;
        {alloc_dest, read_index, complete_tag, complete_value, complete_addr} = '0;
        test_name = "reset";
        rst = 1'b1;
        repeat (3) @(posedge clock);
        rst <= 1'b0;
        check_val("retire_valid", 0, retire_valid);
        check_val("mem_req", 0, mem_req);
        check_val("alloc_ready", 1, alloc_ready);

        test_name = "in_order";   // 8 results completed out of order
        for (int k = 0; k < 8; k++) begin
            dispatch(k[0] ? rob_pkg::OP_LOAD : rob_pkg::OP_ALU, 5'($urandom_range(1, 31)),
                     {$urandom, $urandom}, '0, 1'b0, 1, t);
            tags.push_back(t);
        end
        complete_random(tags);
        wait_drain();
        compare_regfile();

        test_name = "r0_zero";
        tags = {};
        dispatch(rob_pkg::OP_ALU, 5'd0, 64'hdead_beef_0bad_f00d, '0, 1'b0, 1, t);
        tags.push_back(t);
        complete_random(tags);
        wait_drain();
        compare_regfile();

        test_name = "stores";
        tags = {};
        dispatch(rob_pkg::OP_STORE, 5'd3, {$urandom, $urandom}, {$urandom, $urandom}, 0, 1, t);
        tags.push_back(t);
        dispatch(rob_pkg::OP_ALU, 5'd9, {$urandom, $urandom}, '0, 1'b0, 1, t);
        tags.push_back(t);
        dispatch(rob_pkg::OP_STORE, 5'd4, {$urandom, $urandom}, {$urandom, $urandom}, 0, 1, t);
        tags.push_back(t);
        complete_random(tags);
        wait_drain();

        test_name = "mispredict";   // younger work completes first and must vanish
        tags = {};
        dispatch(rob_pkg::OP_BRANCH, 5'd7, 64'h1, '0, 1'b1, 1, br_tag);
        for (int k = 0; k < 3; k++) begin
            dispatch(rob_pkg::OP_ALU, 5'(20 + k), {$urandom, $urandom}, '0, 1'b0, 0, t);
            tags.push_back(t);
        end
        complete_random(tags);
        tags = {br_tag};
        complete_random(tags);
        wait_drain();
        compare_regfile();
        tags = {};
        dispatch(rob_pkg::OP_ALU, 5'd21, {$urandom, $urandom}, '0, 1'b0, 1, t);
        check_val("alloc_tag after flush", 64'(rob_pkg::rob_tag_t'(br_tag + 1'b1)), 64'(t));
        tags.push_back(t);
        complete_random(tags);
        wait_drain();
        compare_regfile();

        test_name = "backpressure";   // ack held while the ROB fills behind the store
        hold_ack <= 1'b1;
        tags = {};
        dispatch(rob_pkg::OP_STORE, 5'd0, {$urandom, $urandom}, {$urandom, $urandom}, 0, 1, t);
        tags.push_back(t);
        complete_random(tags);
        while (!mem_req) @(posedge clock);
        tags = {};
        for (int k = 0; k < `CORE_ROB_DEPTH; k++) begin
            dispatch(rob_pkg::OP_ALU, 5'(k + 1), {$urandom, $urandom}, '0, 1'b0, 1, t);
            tags.push_back(t);
        end
        complete_random(tags);
        @(posedge clock);
        check_val("alloc_ready while full", 0, alloc_ready);
        hold_ack <= 1'b0;
        while (!alloc_ready) @(posedge clock);
        wait_drain();
        compare_regfile();

        if (exp_dest.size() != 0 || st_addr.size() != 0) begin
            abort_run("expected retires or stores never appeared");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
